// File: common/fetch_cfg.svh
// pc and instruction widths are fixed at 32 bits, ram words at 64; reset pc must sit in ram range
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first instruction fetched after reset
`define FETCH_PC_RESET 32'h8000_0000

`define FETCH_PC_WD 32        // byte address width
`define FETCH_INST_WD 32      // one instruction

// one ram word carries two instructions, selected by pc[2]
`define FETCH_RAM_DATA_WD 64

// word index taken from byte address bits [12:3]
`define FETCH_RAM_AW 10

`endif

// File: common/fetch_pkg.sv
// field order is the bit order on the buses, msb first; widths come from fetch_cfg.svh
`include "fetch_cfg.svh"

package fetch_pkg;

  // 34-bit branch info from decode
  typedef struct packed {
    logic                    stall;   // no new fetch may start
    logic                    taken;   // redirect this cycle
    logic [`FETCH_PC_WD-1:0] target;
  } br_bus_t;

  // 96 bits that fetch hands to decode
  typedef struct packed {
    logic [`FETCH_INST_WD-1:0] inst;
    logic [`FETCH_PC_WD-1:0]   pc;
    logic [`FETCH_PC_WD-1:0]   dnpc;    // pc + 4
  } fs_to_ds_t;

endpackage

// File: common/inst_sram_if.sv
// one read in flight at most; rdata and data_ok hold until the next accepted read
`timescale 1ns/1ps
`include "fetch_cfg.svh"

interface inst_sram_if;

  logic                          ren;      // read request
  logic [`FETCH_PC_WD-1:0]       addr;     // 8-byte aligned byte address
  logic [`FETCH_RAM_DATA_WD-1:0] rdata;
  logic                          addr_ok;  // ram can take a request
  logic                          data_ok;  // rdata valid

  // fetch side
  modport master (
    output ren,
    output addr,
    input  rdata,
    input  addr_ok,
    input  data_ok
  );

  // ram side
  modport slave (
    input  ren,
    input  addr,
    output rdata,
    output addr_ok,
    output data_ok
  );

endinterface

// File: if_stage/pc_gen.sv
// branch target is taken as given, no alignment check; pc resets to one step before FETCH_PC_RESET
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module pc_gen (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_load,        // fetch launched this cycle
  input  logic                    i_br_taken,
  input  logic [`FETCH_PC_WD-1:0] i_br_target,
  output logic [`FETCH_PC_WD-1:0] o_pc,
  output logic [`FETCH_PC_WD-1:0] o_dnpc,
  output logic [`FETCH_PC_WD-1:0] o_fetch_addr
);

  localparam logic [`FETCH_PC_WD-1:0] PC_STEP = `FETCH_PC_WD'(4);

  logic [`FETCH_PC_WD-1:0] pc_q;      // pc of instruction held in fetch
  logic [`FETCH_PC_WD-1:0] seq_pc;

  assign seq_pc = pc_q + PC_STEP;

  // redirect wins over sequential flow
  assign o_fetch_addr = i_br_taken ? i_br_target : seq_pc;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= `FETCH_PC_RESET - PC_STEP;  // so the first fetch hits the reset pc
    end else if (i_load) begin
      pc_q <= o_fetch_addr;
    end
  end

  assign o_pc   = pc_q;
  assign o_dnpc = seq_pc;                 // decode sees pc + 4

endmodule

// File: if_stage/if_stage.sv
// expects ram data one cycle after an accepted read; a stall blocks new fetches but not delivery
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module if_stage (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_ds_allowin,
  input  fetch_pkg::br_bus_t   i_br_bus,
  output logic                 o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_t o_fs_to_ds_bus,
  inst_sram_if.master          sram
);

  logic                      fs_valid;
  logic                      fs_ready_go;
  logic                      fs_allowin;
  logic                      fs_launch;
  logic [`FETCH_PC_WD-1:0]   fs_pc;
  logic [`FETCH_PC_WD-1:0]   fs_dnpc;
  logic [`FETCH_PC_WD-1:0]   fetch_addr;
  logic [`FETCH_INST_WD-1:0] fs_inst;

  // instruction is ready once the ram has returned it
  assign fs_ready_go = sram.data_ok;

  // empty, or current instruction leaves this cycle
  assign fs_allowin = !fs_valid || (fs_ready_go && i_ds_allowin);

  // start a new fetch into the freed slot
  assign fs_launch = fs_allowin && sram.addr_ok && !i_br_bus.stall;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid <= fs_launch;     // empties when stalled or ram busy
    end
  end

  pc_gen u_pc_gen (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_load       (fs_launch),
    .i_br_taken   (i_br_bus.taken),
    .i_br_target  (i_br_bus.target),
    .o_pc         (fs_pc),
    .o_dnpc       (fs_dnpc),
    .o_fetch_addr (fetch_addr)
  );

  // request matches launch exactly, since addr_ok gates both
  assign sram.ren  = fs_allowin && !i_br_bus.stall;
  assign sram.addr = {fetch_addr[`FETCH_PC_WD-1:3], 3'b000};  // whole 64-bit word

  // pc[2] picks the half of the ram word
  assign fs_inst = fs_pc[2] ? sram.rdata[2*`FETCH_INST_WD-1:`FETCH_INST_WD]
                            : sram.rdata[`FETCH_INST_WD-1:0];

  assign o_fs_to_ds_valid = fs_valid && fs_ready_go;

  assign o_fs_to_ds_bus.inst = fs_inst;
  assign o_fs_to_ds_bus.pc   = fs_pc;
  assign o_fs_to_ds_bus.dnpc = fs_dnpc;

endmodule

// File: verilog/inst_ram.sv
// 1024 words of 64 bits, no reset on contents; write port is for preload only, no read-write bypass
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module inst_ram (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_we,
  input  logic [`FETCH_RAM_AW-1:0]      i_waddr,   // word index
  input  logic [`FETCH_RAM_DATA_WD-1:0] i_wdata,
  inst_sram_if.slave                    sram
);

  localparam int unsigned DEPTH = 1 << `FETCH_RAM_AW;

  logic [`FETCH_RAM_DATA_WD-1:0] mem [DEPTH];
  logic [`FETCH_RAM_DATA_WD-1:0] rdata_q;
  logic [`FETCH_RAM_AW-1:0]      rd_index;
  logic                          rd_accept;
  logic                          ready_q;
  logic                          data_ok_q;

  assign rd_index  = sram.addr[`FETCH_RAM_AW+2:3];   // byte addr to word index
  assign rd_accept = sram.ren && ready_q;

  // preload port
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // output register holds until the next accepted read
  always_ff @(posedge i_clk) begin
    if (rd_accept) begin
      rdata_q <= mem[rd_index];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ready_q   <= 1'b0;
      data_ok_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;             // takes requests from the cycle after reset
      if (rd_accept) begin
        data_ok_q <= 1'b1;         // stays up with the held data
      end
    end
  end

  assign sram.addr_ok = ready_q;
  assign sram.data_ok = data_ok_q;
  assign sram.rdata   = rdata_q;

endmodule

// File: verilog/fetch_top.sv
// decode is reduced to i_ds_allowin and the branch inputs; ram preload goes through i_ram_we
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic                          i_ds_allowin,
  input  logic                          i_br_stall,
  input  logic                          i_br_taken,
  input  logic [`FETCH_PC_WD-1:0]       i_br_target,
  input  logic                          i_ram_we,
  input  logic [`FETCH_RAM_AW-1:0]      i_ram_waddr,
  input  logic [`FETCH_RAM_DATA_WD-1:0] i_ram_wdata,
  output logic                          o_fs_to_ds_valid,
  output logic [`FETCH_INST_WD-1:0]     o_inst,
  output logic [`FETCH_PC_WD-1:0]       o_pc,
  output logic [`FETCH_PC_WD-1:0]       o_dnpc
);

  import fetch_pkg::*;

  br_bus_t   br_bus;
  fs_to_ds_t fs_to_ds_bus;

  inst_sram_if sram_if ();

  // pack branch inputs
  assign br_bus.stall  = i_br_stall;
  assign br_bus.taken  = i_br_taken;
  assign br_bus.target = i_br_target;

  if_stage u_if_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_allowin     (i_ds_allowin),
    .i_br_bus         (br_bus),
    .o_fs_to_ds_valid (o_fs_to_ds_valid),
    .o_fs_to_ds_bus   (fs_to_ds_bus),
    .sram             (sram_if.master)
  );

  inst_ram u_inst_ram (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_we    (i_ram_we),
    .i_waddr (i_ram_waddr),
    .i_wdata (i_ram_wdata),
    .sram    (sram_if.slave)
  );

  // unpack to decode
  assign o_inst = fs_to_ds_bus.inst;
  assign o_pc   = fs_to_ds_bus.pc;
  assign o_dnpc = fs_to_ds_bus.dnpc;

endmodule

// File: testbench/fetch_checker.sv
// assumes the ram answers each accepted read in the next cycle; sampled on the rising clock
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_checker (
  input logic                      i_clk,
  input logic                      i_reset,
  input logic                      i_fs_to_ds_valid,
  input logic                      i_ds_allowin,
  input logic [`FETCH_INST_WD-1:0] i_inst,
  input logic [`FETCH_PC_WD-1:0]   i_pc,
  input logic [`FETCH_PC_WD-1:0]   i_dnpc,
  input logic                      i_ren,
  input logic                      i_addr_ok,
  input logic                      i_data_ok
);

  // nothing handed to decode while reset holds
  valid_low_in_reset: assert property (
    @(posedge i_clk) i_reset && $past(i_reset) |-> !i_fs_to_ds_valid
  ) else $error("fetch output valid during reset");

  // accepted read is offered to decode one cycle later
  data_after_read: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_ren && i_addr_ok |=> i_data_ok && i_fs_to_ds_valid
  ) else $error("data_ok or fetch valid missing one cycle after an accepted read");

  // decode not ready, so the offer must not move
  stable_under_bp: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_fs_to_ds_valid && !i_ds_allowin |=>
      i_fs_to_ds_valid && $stable(i_inst) && $stable(i_pc) && $stable(i_dnpc)
  ) else $error("fetch output changed under back-pressure");

endmodule

bind fetch_top fetch_checker u_fetch_checker (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_fs_to_ds_valid (o_fs_to_ds_valid),
  .i_ds_allowin     (i_ds_allowin),
  .i_inst           (o_inst),
  .i_pc             (o_pc),
  .i_dnpc           (o_dnpc),
  .i_ren            (sram_if.ren),
  .i_addr_ok        (sram_if.addr_ok),
  .i_data_ok        (sram_if.data_ok)
);

// File: testbench/fetch_tb.sv
// preload of all ram words runs under reset; branch targets stay inside the 8 KB ram window
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int RAM_DEPTH    = 1 << `FETCH_RAM_AW;
  localparam int NUM_INSTS    = 400;
  localparam int PHASE_LEN    = 100;    // deliveries per stimulus phase
  localparam int TEST_CYCLES  = RAM_DEPTH + RESET_CYCLES + NUM_INSTS * 8;

  logic                          clk;
  logic                          reset;
  logic                          ds_allowin;
  logic                          br_stall;
  logic                          br_taken;
  logic [`FETCH_PC_WD-1:0]       br_target;
  logic                          ram_we;
  logic [`FETCH_RAM_AW-1:0]      ram_waddr;
  logic [`FETCH_RAM_DATA_WD-1:0] ram_wdata;
  logic                          fs_to_ds_valid;
  logic [`FETCH_INST_WD-1:0]     inst;
  logic [`FETCH_PC_WD-1:0]       pc;
  logic [`FETCH_PC_WD-1:0]       dnpc;

  integer      seed;
  logic [31:0] rnd;
  logic [31:0] exp_pc;         // next pc decode should see
  int          n_delivered;
  int          n_branch;
  int          n_bp;
  int          n_stall;
  int          hold_left;
  int          phase;
  logic        hold_ds;
  logic        hold_stall;
  logic        branch_now;

  fetch_top DUT (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_ds_allowin     (ds_allowin),
    .i_br_stall       (br_stall),
    .i_br_taken       (br_taken),
    .i_br_target      (br_target),
    .i_ram_we         (ram_we),
    .i_ram_waddr      (ram_waddr),
    .i_ram_wdata      (ram_wdata),
    .o_fs_to_ds_valid (fs_to_ds_valid),
    .o_inst           (inst),
    .o_pc             (pc),
    .o_dnpc           (dnpc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // lower half of word k is byte offset 8k and the upper half 8k+4 tagged by bit 31
  function automatic logic [63:0] preload_word(input int k);
    logic [31:0] lo;
    logic [31:0] hi;
    lo = 32'(8 * k);
    hi = 32'(8 * k + 4) | 32'h8000_0000;
    return {hi, lo};
  endfunction

  // expected instruction straight from the byte address
  function automatic logic [31:0] expected_inst(input logic [31:0] addr);
    return {addr[2], 18'b0, addr[12:0]};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "delivered stream mismatch");
    end
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    ds_allowin = 1'b0;
    br_stall   = 1'b0;
    br_taken   = 1'b0;
    br_target  = '0;
    ram_we     = 1'b0;
    ram_waddr  = '0;
    ram_wdata  = '0;
    seed       = 32'h6ff6_86fa;
    exp_pc     = `FETCH_PC_RESET;
    hold_left  = 0;
    hold_ds    = 1'b1;
    hold_stall = 1'b0;
    n_delivered = 0;
    n_branch    = 0;
    n_bp        = 0;
    n_stall     = 0;
    for (int k = 0; k < RAM_DEPTH; k++) begin
      @(posedge clk);
      ram_we    <= 1'b1;
      ram_waddr <= `FETCH_RAM_AW'(k);
      ram_wdata <= preload_word(k);
    end
    @(posedge clk);
    ram_we <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    wait (n_delivered == NUM_INSTS);
    if (n_branch > 0 && n_bp > 0 && n_stall > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("stimulus never produced a branch, back-pressure or stall cycle");
      $display("*** FAILED ***");
      $fatal(1, "incomplete stimulus");
    end
  end

  // phase 0 plain, 1 back-pressure, 2 stall, 3 everything plus branches
  always @(posedge clk) begin
    if (!reset) begin
      phase = n_delivered / PHASE_LEN;
      rnd   = $random(seed);
      if (hold_left == 0) begin
        hold_left  = 1 + int'(rnd[2:0]);
        hold_ds    = (phase == 1 || phase == 3) ? (rnd[4:3] != 2'b00) : 1'b1;
        hold_stall = (phase == 2 || phase == 3) ? (rnd[6:5] == 2'b00) : 1'b0;
      end else begin
        hold_left = hold_left - 1;
      end
      // redirect only where the fetch slot is sure to launch
      branch_now = (phase == 3) && hold_ds && !hold_stall && (rnd[11:8] == 4'h0);
      ds_allowin <= hold_ds;
      br_stall   <= hold_stall;
      br_taken   <= branch_now;
      br_target  <= branch_now ? (`FETCH_PC_RESET | {19'b0, rnd[24:14], 2'b00}) : '0;
    end
  end

  // compare mid-cycle when inputs and outputs have settled
  always @(negedge clk) begin
    if (!reset) begin
      if (fs_to_ds_valid && ds_allowin) begin
        compare_value("o_pc", pc, exp_pc);
        compare_value("o_inst", inst, expected_inst(exp_pc));
        compare_value("o_dnpc", dnpc, exp_pc + 32'd4);
        exp_pc      = exp_pc + 32'd4;
        n_delivered = n_delivered + 1;
      end
      if (fs_to_ds_valid && !ds_allowin) begin
        n_bp = n_bp + 1;
      end
      if (br_stall) begin
        n_stall = n_stall + 1;
      end
      if (br_taken) begin
        exp_pc   = br_target;    // in-flight one already went out above
        n_branch = n_branch + 1;
      end
    end
  end

  initial begin
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("timeout: only %0d of %0d instructions delivered", n_delivered, NUM_INSTS);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: fetch_top.f
common/fetch_pkg.sv
common/inst_sram_if.sv
if_stage/pc_gen.sv
if_stage/if_stage.sv
verilog/inst_ram.sv
verilog/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv
+incdir+common

// File: Makefile
# Verilator flow for the fetch front end

VERILATOR  ?= verilator
TOP        := fetch_tb
FILELIST   := fetch_top.f
OBJ_DIR    := obj_dir

COMMON_FLAGS := --timing --assert --timescale 1ns/1ps
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
SIM_FLAGS    := --binary $(COMMON_FLAGS) -j 0 --Mdir $(OBJ_DIR)

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary returns a failing status on $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
